//--- common/crg_pkg.sv
package crg_pkg;

    // PLL macro control field widths
    localparam int REFDIV_W  = 6;
    localparam int FBDIV_W   = 12;
    localparam int POSTDIV_W = 3;

    // strap pins, device select on top
    typedef struct packed {
        logic [1:0] dev_sel;
        logic [3:0] core_sel;
    } pll_cfg_t;

    // mirrors the PLL macro control pins
    typedef struct packed {
        logic                 bypass;
        logic [REFDIV_W-1:0]  refdiv;
        logic [FBDIV_W-1:0]   fbdiv;
        logic [POSTDIV_W-1:0] postdiv1;
        logic [POSTDIV_W-1:0] postdiv2;
        logic                 pd;
        logic                 dsmpd;
        logic                 foutpostdivpd;
        logic                 foutvcopd;
    } pll_setting_t;

    localparam pll_setting_t PLL_BYPASS_SETTING = '{
        bypass:        1'b1,
        refdiv:        6'd2,
        fbdiv:         12'd20,
        postdiv1:      3'd1,
        postdiv2:      3'd1,
        pd:            1'b0,
        dsmpd:         1'b1,
        foutpostdivpd: 1'b0,
        foutvcopd:     1'b0
    };

    // core PLL, selects 1..CORE_SEL_MAX
    localparam int CORE_SEL_MAX = 8;
    localparam logic [REFDIV_W-1:0]  CORE_REFDIV   = 6'd2;
    localparam int                   CORE_FB_STEP  = 4;
    localparam int                   CORE_FB_BASE  = 4;
    localparam logic [POSTDIV_W-1:0] CORE_POSTDIV1 = 3'd2;
    localparam logic [POSTDIV_W-1:0] CORE_POSTDIV2 = 3'd1;

    // device PLL, select 1
    localparam logic [REFDIV_W-1:0]  DEV1_REFDIV   = 6'd4;
    localparam logic [FBDIV_W-1:0]   DEV1_FBDIV    = 12'd30;
    localparam logic [POSTDIV_W-1:0] DEV1_POSTDIV1 = 3'd5;
    localparam logic [POSTDIV_W-1:0] DEV1_POSTDIV2 = 3'd1;

    // device PLL, select 2
    localparam logic [REFDIV_W-1:0]  DEV2_REFDIV   = 6'd2;
    localparam logic [FBDIV_W-1:0]   DEV2_FBDIV    = 12'd24;
    localparam logic [POSTDIV_W-1:0] DEV2_POSTDIV1 = 3'd3;
    localparam logic [POSTDIV_W-1:0] DEV2_POSTDIV2 = 3'd2;

    // reset sequencing
    localparam int SYNC_STAGES     = 3;
    localparam int RST_CNT_W       = 20;
    localparam int RST_HOLD_CYCLES = 131071;

endpackage

//--- reset/reset_sync.sv
`timescale 1ns/1ps

// async assert, sync release
module reset_sync
    import crg_pkg::*;
(
    input  logic sys_clk,
    input  logic arst_n,
    output logic sync_n
);

    logic [SYNC_STAGES-1:0] stage;

    // shift a one in after release
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            stage <= '0;
        end else begin
            stage <= {stage[SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign sync_n = stage[SYNC_STAGES-1];

    // release only ripples through the chain
    a_release_ordered: assert property (
        @(posedge sys_clk) disable iff (!arst_n)
        $rose(sync_n) |-> $past(stage[SYNC_STAGES-2])
    ) else $error("reset_sync: output released ahead of previous stage");

endmodule

//--- reset/reset_hold_counter.sv
`timescale 1ns/1ps

module reset_hold_counter
    import crg_pkg::*;
#(
    parameter int unsigned hold_cycles = RST_HOLD_CYCLES
) (
    input  logic sys_clk,
    input  logic arst_n,
    output logic hold_done
);

    localparam logic [RST_CNT_W-1:0] hold_limit = RST_CNT_W'(hold_cycles);

    logic [RST_CNT_W-1:0] cnt;

    // limit has to fit the counter
    if (hold_cycles >= (64'd1 << RST_CNT_W)) begin : g_bad_hold
        $error("reset_hold_counter: hold_cycles out of counter range");
    end

    // count up and stop at the limit
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (!hold_done) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign hold_done = (cnt == hold_limit);

    a_cnt_saturates: assert property (
        @(posedge sys_clk) disable iff (!arst_n)
        cnt <= hold_limit
    ) else $error("reset_hold_counter: count %0d past limit %0d", cnt, hold_limit);

endmodule

//--- verilog/pll_cfg_decode.sv
`timescale 1ns/1ps

// strap word to PLL macro settings, purely combinational
module pll_cfg_decode
    import crg_pkg::*;
(
    input  logic         sys_clk,
    input  pll_cfg_t     pll_cfg,
    output pll_setting_t core_pll,
    output pll_setting_t dev_pll
);

    logic [FBDIV_W-1:0] core_fbdiv;
    logic               core_run;

    // a running PLL always has the same control bits
    function automatic pll_setting_t run_setting(
        input logic [REFDIV_W-1:0]  refdiv,
        input logic [FBDIV_W-1:0]   fbdiv,
        input logic [POSTDIV_W-1:0] postdiv1,
        input logic [POSTDIV_W-1:0] postdiv2
    );
        pll_setting_t s;
        s.bypass        = 1'b0;
        s.refdiv        = refdiv;
        s.fbdiv         = fbdiv;
        s.postdiv1      = postdiv1;
        s.postdiv2      = postdiv2;
        s.pd            = 1'b0;
        s.dsmpd         = 1'b1;
        s.foutpostdivpd = 1'b0;
        s.foutvcopd     = 1'b0;
        return s;
    endfunction

    // feedback divider scales with select, 20 at select 1
    assign core_fbdiv = FBDIV_W'(CORE_FB_STEP * (int'(pll_cfg.core_sel) + CORE_FB_BASE));

    // select 0 and anything above the table go to bypass
    assign core_run = (pll_cfg.core_sel != '0) &&
                      (int'(pll_cfg.core_sel) <= CORE_SEL_MAX);

    always_comb begin
        if (core_run) begin
            core_pll = run_setting(CORE_REFDIV, core_fbdiv,
                                   CORE_POSTDIV1, CORE_POSTDIV2);
        end else begin
            core_pll = PLL_BYPASS_SETTING;
        end
    end

    // device PLL, two rates
    always_comb begin
        case (pll_cfg.dev_sel)
            2'd1: begin
                dev_pll = run_setting(DEV1_REFDIV, DEV1_FBDIV,
                                      DEV1_POSTDIV1, DEV1_POSTDIV2);
            end
            2'd2: begin
                dev_pll = run_setting(DEV2_REFDIV, DEV2_FBDIV,
                                      DEV2_POSTDIV1, DEV2_POSTDIV2);
            end
            default: begin
                dev_pll = PLL_BYPASS_SETTING;
            end
        endcase
    end

    // clean straps give clean settings
    a_no_x_out: assert property (
        @(posedge sys_clk)
        !$isunknown(pll_cfg) |-> !$isunknown({core_pll, dev_pll})
    ) else $error("pll_cfg_decode: unknown bits in PLL settings for strap %b", pll_cfg);

endmodule

//--- verilog/crg_top.sv
`timescale 1ns/1ps

// reset chain and PLL strap decode
module crg_top
    import crg_pkg::*;
#(
    parameter int unsigned hold_cycles = RST_HOLD_CYCLES
) (
    input  logic         sys_clk,
    input  logic         rst_gen,
    input  pll_cfg_t     pll_cfg,
    output pll_setting_t core_pll,
    output pll_setting_t dev_pll,
    output logic         rst_core_n
);

    logic rst_sync_n;
    logic hold_done;

    // board reset into the clock domain
    reset_sync sync_gen_inst (
        .sys_clk (sys_clk),
        .arst_n  (rst_gen),
        .sync_n  (rst_sync_n)
    );

    reset_hold_counter #(
        .hold_cycles (hold_cycles)
    ) hold_cnt_inst (
        .sys_clk   (sys_clk),
        .arst_n    (rst_sync_n),
        .hold_done (hold_done)
    );

    // hold_done is a compare output, resync before use
    reset_sync sync_core_inst (
        .sys_clk (sys_clk),
        .arst_n  (hold_done),
        .sync_n  (rst_core_n)
    );

    pll_cfg_decode decode_inst (
        .sys_clk  (sys_clk),
        .pll_cfg  (pll_cfg),
        .core_pll (core_pll),
        .dev_pll  (dev_pll)
    );

endmodule

//--- bench/crg_tb.sv
`timescale 1ns/1ps

module crg_tb
    import crg_pkg::*;
();

    localparam int hold_len       = 32;
    localparam int reset_len      = 10;
    localparam int case_count     = 64;
    localparam int timeout_cycles = 2 * (2 * (hold_len + reset_len) + case_count);

    logic         sys_clk;
    logic         rst_gen;
    pll_cfg_t     pll_cfg;
    pll_setting_t core_pll;
    pll_setting_t dev_pll;
    logic         rst_core_n;

    logic [5:0]   case_strap [case_count];
    pll_setting_t case_core  [case_count];
    pll_setting_t case_dev   [case_count];
    int           cases_loaded = 0;

    integer seed;
    int     cycle_cnt  = 0;
    int     check_cnt  = 0;
    int     error_cnt  = 0;
    int     test_cnt   = 0;
    int     check_base = 0;
    int     error_base = 0;

    crg_top #(
        .hold_cycles (hold_len)
    ) crg_top_inst (
        .sys_clk    (sys_clk),
        .rst_gen    (rst_gen),
        .pll_cfg    (pll_cfg),
        .core_pll   (core_pll),
        .dev_pll    (dev_pll),
        .rst_core_n (rst_core_n)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #4 sys_clk = ~sys_clk;
        end
    end

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // nine file columns in pll_setting_t field order
    function automatic pll_setting_t to_setting(input int v [9]);
        pll_setting_t s;
        s.bypass        = 1'(v[0]);
        s.refdiv        = REFDIV_W'(v[1]);
        s.fbdiv         = FBDIV_W'(v[2]);
        s.postdiv1      = POSTDIV_W'(v[3]);
        s.postdiv2      = POSTDIV_W'(v[4]);
        s.pd            = 1'(v[5]);
        s.dsmpd         = 1'(v[6]);
        s.foutpostdivpd = 1'(v[7]);
        s.foutvcopd     = 1'(v[8]);
        return s;
    endfunction

    task automatic load_cases();
        int    fd;
        int    n;
        int    strap;
        int    cf [9];
        int    df [9];
        string line;
        fd = $fopen("bench/crg_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/crg_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#" && cases_loaded < case_count) begin
                    n = $sscanf(line,
                        "%h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        strap, cf[0], cf[1], cf[2], cf[3], cf[4], cf[5], cf[6], cf[7],
                        cf[8], df[0], df[1], df[2], df[3], df[4], df[5], df[6], df[7],
                        df[8]);
                    if (n == 19) begin
                        case_strap[cases_loaded] = 6'(strap);
                        case_core[cases_loaded]  = to_setting(cf);
                        case_dev[cases_loaded]   = to_setting(df);
                        cases_loaded++;
                    end else begin
                        $display("malformed line in cases file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_setting(input string name, input pll_setting_t actual,
                                 input pll_setting_t expected);
        check_cnt++;
        assert (actual === expected) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
            error_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        check_cnt++;
        assert (actual === expected) else begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
            error_cnt++;
        end
    endtask

    // called right after a falling edge
    task automatic apply_and_check(input int idx, input logic want_rst);
        pll_cfg = case_strap[idx];
        @(negedge sys_clk);
        check_setting("core_pll", core_pll, case_core[idx]);
        check_setting("dev_pll", dev_pll, case_dev[idx]);
        check_bit("rst_core_n", rst_core_n, want_rst);
    endtask

    task automatic decode_in_reset(input int cycles);
        int idx;
        repeat (cycles) begin
            idx = int'($unsigned($random(seed)) % case_count);
            apply_and_check(idx, 1'b0);
        end
    endtask

    // rst_gen was just released on a falling edge
    task automatic check_release_window();
        int edge_n;
        for (edge_n = 1; edge_n <= hold_len + 4; edge_n++) begin
            @(negedge sys_clk);
            check_bit("rst_core_n", rst_core_n, 1'b0);
        end
        edge_n = hold_len + 4;
        while (rst_core_n !== 1'b1 && edge_n < hold_len + 7) begin
            @(negedge sys_clk);
            edge_n++;
        end
        if (rst_core_n !== 1'b1) begin
            $display("rst_core_n still low %0d edges after release", edge_n);
        end
        check_bit("rst_core_n", rst_core_n, 1'b1);
        repeat (4) begin
            @(negedge sys_clk);
            check_bit("rst_core_n", rst_core_n, 1'b1);
        end
    endtask

    task automatic start_test();
        check_base = check_cnt;
        error_base = error_cnt;
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("test %s finished: %0d checks, %0d errors", name,
                 check_cnt - check_base, error_cnt - error_base);
    endtask

    initial begin
        int i;
        rst_gen = 1'b0;
        pll_cfg = '0;
        seed    = 32'ha04deac6;
        load_cases();
        if (cases_loaded == case_count) begin
            // straps decode while the first reset is held
            start_test();
            decode_in_reset(reset_len);
            report_test("decode_in_reset");

            start_test();
            rst_gen = 1'b1;
            check_release_window();
            report_test("reset_release");

            start_test();
            for (i = 0; i < case_count; i++) begin
                apply_and_check(i, 1'b1);
            end
            report_test("decode_all_straps");

            // async drop, no clock edge in between
            start_test();
            rst_gen = 1'b0;
            #1;
            check_bit("rst_core_n", rst_core_n, 1'b0);
            @(negedge sys_clk);
            decode_in_reset(reset_len);
            report_test("mid_run_reset");

            start_test();
            rst_gen = 1'b1;
            check_release_window();
            report_test("reset_rerelease");
        end else begin
            $display("cases file gave %0d usable lines, %0d needed", cases_loaded, case_count);
            error_cnt++;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/crg_cases.txt
# strap(hex), then core PLL: bypass refdiv fbdiv postdiv1 postdiv2 pd dsmpd foutpostdivpd foutvcopd
# then device PLL with the same nine fields, all fields decimal
00  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
01  0 2 20 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
02  0 2 24 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
03  0 2 28 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
04  0 2 32 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
05  0 2 36 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
06  0 2 40 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
07  0 2 44 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
08  0 2 48 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
09  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
0a  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
0b  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
0c  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
0d  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
0e  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
0f  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
10  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
11  0 2 20 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
12  0 2 24 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
13  0 2 28 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
14  0 2 32 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
15  0 2 36 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
16  0 2 40 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
17  0 2 44 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
18  0 2 48 2 1 0 1 0 0  0 4 30 5 1 0 1 0 0
19  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
1a  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
1b  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
1c  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
1d  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
1e  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
1f  1 2 20 1 1 0 1 0 0  0 4 30 5 1 0 1 0 0
20  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
21  0 2 20 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
22  0 2 24 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
23  0 2 28 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
24  0 2 32 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
25  0 2 36 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
26  0 2 40 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
27  0 2 44 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
28  0 2 48 2 1 0 1 0 0  0 2 24 3 2 0 1 0 0
29  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
2a  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
2b  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
2c  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
2d  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
2e  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
2f  1 2 20 1 1 0 1 0 0  0 2 24 3 2 0 1 0 0
30  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
31  0 2 20 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
32  0 2 24 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
33  0 2 28 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
34  0 2 32 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
35  0 2 36 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
36  0 2 40 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
37  0 2 44 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
38  0 2 48 2 1 0 1 0 0  1 2 20 1 1 0 1 0 0
39  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
3a  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
3b  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
3c  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
3d  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
3e  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0
3f  1 2 20 1 1 0 1 0 0  1 2 20 1 1 0 1 0 0

//--- list.f
common/crg_pkg.sv
reset/reset_sync.sv
reset/reset_hold_counter.sv
verilog/pll_cfg_decode.sv
verilog/crg_top.sv
bench/crg_tb.sv

//--- Makefile
# Verilator simulation of the clock and reset generator

VERILATOR ?= verilator
TOP       ?= crg_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
